//--- rtl/hdmi_out_config.svh
`ifndef HDMI_OUT_CONFIG_SVH
`define HDMI_OUT_CONFIG_SVH

// horizontal raster timing in pixels
`define H_ACTIVE 16
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 3
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical raster timing in lines
`define V_ACTIVE 8
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// frame buffer read port
`define FB_ADDR_W 15

// osd character grid, square cells
`define OSD_COLS 4
`define OSD_ROWS 2
`define OSD_CELL 4

// cycles spent in startup before a trigger is accepted
`define STARTUP_CYCLES 40

// address reg, buffer read, mixer reg
`define PIPE_DEPTH 3

`endif

//--- rtl/hdmi_out_pkg.sv
package hdmi_out_pkg;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    // all levels active high
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_t;

    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
    } raster_pos_t;

    // one text cell write per cycle with wren set
    typedef struct packed {
        logic       wren;
        logic [2:0] addr;
        logic [7:0] character;
    } text_wr_t;

    typedef struct packed {
        logic       enable;
        logic [1:0] highlight_row;
    } osd_cfg_t;

    typedef struct packed {
        sync_t  sync;
        pixel_t pixel;
    } video_out_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_startup,
        seq_wait_trigger,
        seq_run
    } seq_state_t;

endpackage

//--- rtl/stage_delay.sv
`timescale 1ns/10ps
`include "hdmi_out_config.svh"

module stage_delay #(
    parameter type payload_t = logic
) (
    input  logic     hdmi_clock,
    input  logic     reset_dc_out,
    input  payload_t din,
    output payload_t dout
);
    import hdmi_out_pkg::*;

    // sync rides the whole pipe, position stops one short to meet rddata
    localparam int depth = ($bits(payload_t) == $bits(sync_t)) ?
                           `PIPE_DEPTH : `PIPE_DEPTH - 1;

    payload_t stages [depth];

    always_ff @(posedge hdmi_clock) begin
        if (reset_dc_out) begin
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= din;
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[depth-1];

endmodule

//--- rtl/raster_counter.sv
`timescale 1ns/10ps
`include "hdmi_out_config.svh"

module raster_counter (
    input  logic                      hdmi_clock,
    input  logic                      reset_dc_out,
    input  logic                      run,
    output hdmi_out_pkg::raster_pos_t pos,
    output hdmi_out_pkg::sync_t       sync
);
    import hdmi_out_pkg::*;

    logic [11:0] x_q;
    logic [11:0] y_q;
    logic        x_last;
    logic        y_last;

    assign x_last = (x_q == 12'(`H_TOTAL - 1));
    assign y_last = (y_q == 12'(`V_TOTAL - 1));

    //////////////////////////////////////////////////
    // position counters
    //////////////////////////////////////////////////
    always_ff @(posedge hdmi_clock) begin
        if (reset_dc_out) begin
            x_q <= '0;
            y_q <= '0;
        end else if (!run) begin
            // parked at the top left until started
            x_q <= '0;
            y_q <= '0;
        end else if (x_last) begin
            x_q <= '0;
            y_q <= y_last ? 12'd0 : y_q + 12'd1;
        end else begin
            x_q <= x_q + 12'd1;
        end
    end

    assign pos.x = x_q;
    assign pos.y = y_q;

    //////////////////////////////////////////////////
    // sync and active area decode
    //////////////////////////////////////////////////
    always_comb begin
        sync = '0;
        if (run) begin
            sync.de    = (x_q < `H_ACTIVE) && (y_q < `V_ACTIVE);
            sync.hsync = (x_q >= `H_ACTIVE + `H_FRONT) &&
                         (x_q < `H_ACTIVE + `H_FRONT + `H_SYNC);
            sync.vsync = (y_q >= `V_ACTIVE + `V_FRONT) &&
                         (y_q < `V_ACTIVE + `V_FRONT + `V_SYNC);
        end
    end

endmodule

//--- rtl/output_sequencer.sv
`timescale 1ns/10ps
`include "hdmi_out_config.svh"

module output_sequencer (
    input  logic hdmi_clock,
    input  logic reset_dc_out,
    input  logic start_trigger,
    input  logic resync,
    output logic run
);
    import hdmi_out_pkg::*;

    seq_state_t  state_q;
    logic [15:0] startup_count;

    //////////////////////////////////////////////////
    // start order: idle, startup delay, wait, run
    //////////////////////////////////////////////////
    always_ff @(posedge hdmi_clock) begin
        if (reset_dc_out) begin
            state_q       <= seq_idle;
            startup_count <= '0;
        end else begin
            unique case (state_q)
                seq_idle: begin
                    startup_count <= '0;
                    state_q       <= seq_startup;
                end
                seq_startup: begin
                    // early triggers fall through here unseen
                    if (startup_count == 16'(`STARTUP_CYCLES - 1)) begin
                        state_q <= seq_wait_trigger;
                    end else begin
                        startup_count <= startup_count + 16'd1;
                    end
                end
                seq_wait_trigger: begin
                    if (start_trigger) begin
                        state_q <= seq_run;
                    end
                end
                seq_run: begin
                    // back to waiting, next trigger restarts the raster
                    if (resync) begin
                        state_q <= seq_wait_trigger;
                    end
                end
                default: begin
                    state_q <= seq_idle;
                end
            endcase
        end
    end

    assign run = (state_q == seq_run);

endmodule

//--- rtl/frame_reader.sv
`timescale 1ns/10ps
`include "hdmi_out_config.svh"

module frame_reader (
    input  logic                      hdmi_clock,
    input  logic                      reset_dc_out,
    input  hdmi_out_pkg::raster_pos_t pos,
    input  logic                      line_doubler,
    output logic [`FB_ADDR_W-1:0]     rdaddr
);
    import hdmi_out_pkg::*;

    logic [11:0]           src_row;
    logic [`FB_ADDR_W-1:0] addr_next;

    // doubled mode repeats each buffer line on two raster lines
    always_comb begin
        if (line_doubler) begin
            src_row = pos.y >> 1;
        end else begin
            src_row = pos.y;
        end
        addr_next = `FB_ADDR_W'(src_row * `H_ACTIVE + pos.x);
    end

    //////////////////////////////////////////////////
    // registered read address, first pipe stage
    //////////////////////////////////////////////////
    always_ff @(posedge hdmi_clock) begin
        if (reset_dc_out) begin
            rdaddr <= '0;
        end else begin
            rdaddr <= addr_next;
        end
    end

endmodule

//--- rtl/osd_mixer.sv
`timescale 1ns/10ps
`include "hdmi_out_config.svh"

module osd_mixer (
    input  logic                      hdmi_clock,
    input  logic                      reset_dc_out,
    input  hdmi_out_pkg::raster_pos_t pos,
    input  hdmi_out_pkg::sync_t       sync,
    input  hdmi_out_pkg::pixel_t      rddata,
    input  hdmi_out_pkg::text_wr_t    text_wr,
    input  hdmi_out_pkg::osd_cfg_t    osd_cfg,
    output hdmi_out_pkg::video_out_t  video
);
    import hdmi_out_pkg::*;

    localparam pixel_t osd_white  = 24'hffffff;
    localparam pixel_t osd_yellow = 24'hffff00;

    logic [7:0]  text_mem [`OSD_COLS * `OSD_ROWS];
    logic [11:0] cell_col;
    logic [11:0] cell_row;
    logic        in_grid;
    logic [2:0]  cell_addr;
    logic [7:0]  cell_char;
    pixel_t      pix_next;
    pixel_t      pix_q;

    //////////////////////////////////////////////////
    // text ram, one byte per cell
    //////////////////////////////////////////////////
    always_ff @(posedge hdmi_clock) begin
        if (text_wr.wren) begin
            text_mem[text_wr.addr] <= text_wr.character;
        end
    end

    // cell lookup runs alongside the buffer read
    always_comb begin
        cell_col  = pos.x / `OSD_CELL;
        cell_row  = pos.y / `OSD_CELL;
        in_grid   = (cell_col < `OSD_COLS) && (cell_row < `OSD_ROWS);
        cell_addr = 3'(cell_row * `OSD_COLS + cell_col);
        cell_char = text_mem[cell_addr];
    end

    //////////////////////////////////////////////////
    // overlay select
    //////////////////////////////////////////////////
    always_comb begin
        pix_next = rddata;
        if (osd_cfg.enable && in_grid && (cell_char != 8'd0)) begin
            if (cell_row == 12'(osd_cfg.highlight_row)) begin
                pix_next = osd_yellow;
            end else begin
                pix_next = osd_white;
            end
        end
    end

    always_ff @(posedge hdmi_clock) begin
        if (reset_dc_out) begin
            pix_q <= '0;
        end else begin
            pix_q <= pix_next;
        end
    end

    // sync arrives already aligned with pix_q, blank outside de
    always_comb begin
        video.sync  = sync;
        video.pixel = sync.de ? pix_q : pixel_t'('0);
    end

endmodule

//--- rtl/hdmi_video_out.sv
`timescale 1ns/10ps
`include "hdmi_out_config.svh"

module hdmi_video_out (
    input  logic                     hdmi_clock,
    input  logic                     reset_dc_out,
    input  logic                     start_trigger,
    input  logic                     resync,
    input  logic                     line_doubler,
    input  hdmi_out_pkg::text_wr_t   text_wr,
    input  hdmi_out_pkg::osd_cfg_t   osd_cfg,
    input  hdmi_out_pkg::pixel_t     rddata,
    output logic [`FB_ADDR_W-1:0]    rdaddr,
    output hdmi_out_pkg::video_out_t video
);
    import hdmi_out_pkg::*;

    logic        run;
    raster_pos_t pos;
    sync_t       sync;
    raster_pos_t pos_dly;
    sync_t       sync_dly;

    //////////////////////////////////////////////////
    // control and raster timing
    //////////////////////////////////////////////////
    output_sequencer u_sequencer (
        .hdmi_clock    (hdmi_clock),
        .reset_dc_out  (reset_dc_out),
        .start_trigger (start_trigger),
        .resync        (resync),
        .run           (run)
    );

    raster_counter u_raster (
        .hdmi_clock   (hdmi_clock),
        .reset_dc_out (reset_dc_out),
        .run          (run),
        .pos          (pos),
        .sync         (sync)
    );

    //////////////////////////////////////////////////
    // pixel pipeline
    //////////////////////////////////////////////////
    frame_reader u_reader (
        .hdmi_clock   (hdmi_clock),
        .reset_dc_out (reset_dc_out),
        .pos          (pos),
        .line_doubler (line_doubler),
        .rdaddr       (rdaddr)
    );

    stage_delay #(.payload_t(sync_t)) u_sync_delay (
        .hdmi_clock   (hdmi_clock),
        .reset_dc_out (reset_dc_out),
        .din          (sync),
        .dout         (sync_dly)
    );

    stage_delay #(.payload_t(raster_pos_t)) u_pos_delay (
        .hdmi_clock   (hdmi_clock),
        .reset_dc_out (reset_dc_out),
        .din          (pos),
        .dout         (pos_dly)
    );

    osd_mixer u_mixer (
        .hdmi_clock   (hdmi_clock),
        .reset_dc_out (reset_dc_out),
        .pos          (pos_dly),
        .sync         (sync_dly),
        .rddata       (rddata),
        .text_wr      (text_wr),
        .osd_cfg      (osd_cfg),
        .video        (video)
    );

endmodule

//--- dv/hdmi_video_out_props.sv
`timescale 1ns/10ps
`include "hdmi_out_config.svh"

module hdmi_video_out_props (
    input logic                     hdmi_clock,
    input logic                     reset_dc_out,
    input logic                     run,
    input hdmi_out_pkg::video_out_t video
);
    import hdmi_out_pkg::*;

    logic [7:0] hsync_len;
    logic [2:0] run_hist;

    // hsync run length and the last three run levels
    always_ff @(posedge hdmi_clock) begin
        if (reset_dc_out) begin
            hsync_len <= '0;
            run_hist  <= '0;
        end else begin
            hsync_len <= video.sync.hsync ? hsync_len + 8'd1 : 8'd0;
            run_hist  <= {run_hist[1:0], run};
        end
    end

    de_outside_sync: assert property (@(posedge hdmi_clock) disable iff (reset_dc_out)
        !(video.sync.de && (video.sync.hsync || video.sync.vsync)))
        else $error("de set during hsync or vsync");

    hsync_width: assert property (@(posedge hdmi_clock) disable iff (reset_dc_out)
        $fell(video.sync.hsync) |-> (hsync_len == 8'(`H_SYNC)))
        else $error("hsync pulse width wrong");

    // pipe drained once run has been low for the whole depth
    quiet_when_stopped: assert property (@(posedge hdmi_clock) disable iff (reset_dc_out)
        (!run && run_hist == 3'b000) |-> (video == '0))
        else $error("video active while stopped");

endmodule

bind hdmi_video_out hdmi_video_out_props u_props (
    .hdmi_clock   (hdmi_clock),
    .reset_dc_out (reset_dc_out),
    .run          (run),
    .video        (video)
);

//--- dv/hdmi_video_out_tb.sv
`timescale 1ns/10ps
`include "hdmi_out_config.svh"

module hdmi_video_out_tb;
    import hdmi_out_pkg::*;

    localparam int frame_pixels  = `H_ACTIVE * `V_ACTIVE;
    localparam int frame_timeout = 4 * `H_TOTAL * `V_TOTAL;

    logic                  hdmi_clock = 1'b0;
    logic                  reset_dc_out;
    logic                  start_trigger;
    logic                  resync;
    logic                  line_doubler;
    text_wr_t              text_wr;
    osd_cfg_t              osd_cfg;
    pixel_t                rddata = '0;
    logic [`FB_ADDR_W-1:0] rdaddr;
    video_out_t            video;

    logic [7:0][7:0] text_img;
    logic [31:0]     lcg_state = 32'hff3f9b01;
    logic            compare_on;
    sync_t           prev_sync = '0;
    int              pixel_idx = 0;
    int              frames_done = 0;
    int              windows_checked = 0;
    logic            window_valid = 1'b0;
    int              de_count = 0;
    int              hs_count = 0;
    int              vs_count = 0;
    int              vs_cycles = 0;

    always #10 hdmi_clock = ~hdmi_clock;

    hdmi_video_out u_dut (
        .hdmi_clock    (hdmi_clock),
        .reset_dc_out  (reset_dc_out),
        .start_trigger (start_trigger),
        .resync        (resync),
        .line_doubler  (line_doubler),
        .text_wr       (text_wr),
        .osd_cfg       (osd_cfg),
        .rddata        (rddata),
        .rdaddr        (rdaddr),
        .video         (video)
    );

    //////////////////////////////////////////////////
    // frame buffer model and reference
    //////////////////////////////////////////////////
    function automatic pixel_t ram_hash(input logic [`FB_ADDR_W-1:0] addr);
        logic [31:0] h;
        h = 32'(addr) * 32'h9e3779b1;
        h = h ^ (h >> 13);
        return pixel_t'(h[23:0]);
    endfunction

    // synchronous read with data one cycle after the address
    always @(posedge hdmi_clock) begin
        rddata <= ram_hash(rdaddr);
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic pixel_t expected_pixel(input int idx, input logic doubler,
                                              input osd_cfg_t cfg,
                                              input logic [7:0][7:0] img);
        int x;
        int y;
        int col;
        int row;
        x   = idx % `H_ACTIVE;
        y   = idx / `H_ACTIVE;
        col = x / `OSD_CELL;
        row = y / `OSD_CELL;
        expected_pixel = ram_hash(`FB_ADDR_W'((doubler ? y / 2 : y) * `H_ACTIVE + x));
        if (cfg.enable && col < `OSD_COLS && row < `OSD_ROWS) begin
            if (img[row * `OSD_COLS + col] != 8'h00) begin
                // yellow in the highlighted row and white elsewhere
                expected_pixel = (row == int'(cfg.highlight_row)) ? 24'hffff00 : 24'hffffff;
            end
        end
    endfunction

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_pixel(input pixel_t expected, input pixel_t actual, input string name);
        if (actual !== expected) begin
            report_failure($sformatf("Fail %s: expected %h, got %h", name, expected, actual));
        end
    endtask

    task automatic check_sync(input sync_t expected, input sync_t actual, input string name);
        if (actual !== expected) begin
            report_failure($sformatf("Fail %s: expected %h, got %h", name, expected, actual));
        end
    endtask

    task automatic check_count(input int expected, input int actual, input string name);
        if (actual != expected) begin
            report_failure($sformatf("Fail %s: expected %h, got %h", name, expected, actual));
        end
    endtask

    // comparing process counts de cycles for x and y
    always @(negedge hdmi_clock) begin
        sync_t cur;
        cur = video.sync;
        if (!compare_on) begin
            pixel_idx    = 0;
            window_valid = 1'b0;
            de_count     = 0;
            hs_count     = 0;
            vs_count     = 0;
            vs_cycles    = 0;
        end else begin
            // a vsync fall closes one frame window
            if (!cur.vsync && prev_sync.vsync) begin
                if (window_valid) begin
                    check_count(frame_pixels, de_count, "video.sync.de count");
                    check_count(`V_TOTAL, hs_count, "video.sync.hsync pulses");
                    check_count(1, vs_count, "video.sync.vsync pulses");
                    check_count(`V_SYNC * `H_TOTAL, vs_cycles, "video.sync.vsync cycles");
                    windows_checked++;
                end
                window_valid = 1'b1;
                de_count     = 0;
                hs_count     = 0;
                vs_count     = 0;
                vs_cycles    = 0;
            end
            if (cur.de) begin
                check_pixel(expected_pixel(pixel_idx, line_doubler, osd_cfg, text_img),
                            video.pixel, $sformatf("video.pixel[%0d]", pixel_idx));
                de_count++;
                pixel_idx++;
                if (pixel_idx == frame_pixels) begin
                    pixel_idx = 0;
                    frames_done++;
                end
            end
            hs_count  += (cur.hsync && !prev_sync.hsync) ? 1 : 0;
            vs_count  += (cur.vsync && !prev_sync.vsync) ? 1 : 0;
            vs_cycles += cur.vsync ? 1 : 0;
        end
        prev_sync = cur;
    end

    //////////////////////////////////////////////////
    // bounded waits
    //////////////////////////////////////////////////
    task automatic wait_frames(input int target);
        int cycles;
        cycles = 0;
        while (frames_done < target) begin
            if (cycles == frame_timeout) begin
                report_failure($sformatf("timed out waiting for frame %0d", target));
            end
            @(posedge hdmi_clock);
            #1;
            cycles++;
        end
    endtask

    task automatic wait_pixel_index(input int target);
        int cycles;
        cycles = 0;
        while (pixel_idx < target) begin
            if (cycles == frame_timeout) begin
                report_failure("timed out waiting for the middle of a frame");
            end
            @(posedge hdmi_clock);
            #1;
            cycles++;
        end
    endtask

    // a whole quiet line means the raster has stopped
    task automatic wait_outputs_idle();
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < `H_TOTAL) begin
            if (cycles == 4 * `H_TOTAL) begin
                report_failure("outputs still active after resync");
            end
            @(negedge hdmi_clock);
            quiet = (video == '0) ? quiet + 1 : 0;
            cycles++;
        end
        @(posedge hdmi_clock);
        #1;
    endtask

    task automatic pulse_trigger();
        start_trigger = 1'b1;
        @(posedge hdmi_clock);
        #1;
        start_trigger = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial begin
        logic [7:0] ch;
        reset_dc_out  = 1'b1;
        start_trigger = 1'b0;
        resync        = 1'b0;
        line_doubler  = 1'b0;
        text_wr       = '0;
        osd_cfg       = '0;
        compare_on    = 1'b0;
        text_img      = '0;
        repeat (5) @(posedge hdmi_clock);
        #1;
        reset_dc_out = 1'b0;

        // idle through startup, text writes and early triggers
        for (int c = 0; c < `STARTUP_CYCLES + 20; c++) begin
            @(posedge hdmi_clock);
            #1;
            // the second trigger lands on the last startup cycle
            start_trigger = (c == 6) || (c == `STARTUP_CYCLES - 1);
            text_wr       = '0;
            if (c < `OSD_COLS * `OSD_ROWS) begin
                lcg_state         = lcg_next(lcg_state);
                // cells 1, 4 and 7 stay empty
                ch                = (c % 3 == 1) ? 8'h00 : (lcg_state[23:16] | 8'h01);
                text_img[c]       = ch;
                text_wr.wren      = 1'b1;
                text_wr.addr      = 3'(c);
                text_wr.character = ch;
            end
            @(negedge hdmi_clock);
            check_sync(sync_t'('0), video.sync, "video.sync");
            check_pixel(pixel_t'('0), video.pixel, "video.pixel");
        end
        @(posedge hdmi_clock);
        #1;
        start_trigger = 1'b0;
        compare_on    = 1'b1;
        pulse_trigger();
        wait_frames(1);
        line_doubler = 1'b1;
        wait_frames(2);
        line_doubler          = 1'b0;
        osd_cfg.enable        = 1'b1;
        osd_cfg.highlight_row = 2'd1;
        wait_frames(3);
        osd_cfg = '0;

        // resync a few lines into the frame
        wait_pixel_index(3 * `H_ACTIVE + 5);
        compare_on = 1'b0;
        resync     = 1'b1;
        @(posedge hdmi_clock);
        #1;
        resync = 1'b0;
        wait_outputs_idle();
        compare_on = 1'b1;
        pulse_trigger();
        wait_frames(4);

        repeat (4) @(posedge hdmi_clock);
        if (frames_done == 4 && windows_checked >= 2) begin
            $display("all tests passed");
            $finish;
        end else begin
            report_failure("fewer frames or frame windows checked than expected");
        end
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/hdmi_out_pkg.sv
rtl/stage_delay.sv
rtl/raster_counter.sv
rtl/output_sequencer.sv
rtl/frame_reader.sv
rtl/osd_mixer.sv
rtl/hdmi_video_out.sv
dv/hdmi_video_out_props.sv
dv/hdmi_video_out_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the hdmi output stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module hdmi_video_out_tb -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
